// ==== compress_pkg.sv ====
// ----------------------------------------------------------
// shared sizes, compressed field widths, mode type, API codes
// and the mode to d mapping
// ----------------------------------------------------------
`default_nettype none

package compress_pkg;

    // ------------------------------------------------------
    // memory and polynomial geometry
    // ------------------------------------------------------
    localparam int mem_addr_width = 10;
    localparam int coeff_per_clk  = 4;
    localparam int reg_size       = 12;
    localparam int mlkem_n        = 256;
    localparam int words_per_poly = mlkem_n / coeff_per_clk;
    localparam int mlkem_q        = 3329;

    // num_poly field and word counter widths
    localparam int num_poly_width = 3;
    localparam int word_idx_width = $clog2(words_per_poly);
    localparam int word_cnt_width = num_poly_width + word_idx_width;

    // ------------------------------------------------------
    // compressed output
    // ------------------------------------------------------
    localparam int comp_max_d     = 11;
    localparam int api_data_width = coeff_per_clk * comp_max_d;

    // x * 2^d + q/2, widest case d = 11
    localparam int comp_num_width   = reg_size + comp_max_d;
    // reciprocal of q scaled by 2^24, floor
    localparam int comp_recip_shift = 24;
    localparam int comp_recip       = (1 << comp_recip_shift) / mlkem_q;
    localparam int comp_recip_width = 13;
    localparam int comp_prod_width  = comp_num_width + comp_recip_width;

    typedef enum logic [1:0] {
        comp_d1  = 2'd0,
        comp_d5  = 2'd1,
        comp_d10 = 2'd2,
        comp_d11 = 2'd3
    } compress_mode_t;

    // API enable encodings, 11 never issued
    localparam logic [1:0] api_en_write = 2'b01;
    localparam logic [1:0] api_en_read  = 2'b10;

    // compressed width d for each mode
    function automatic logic [3:0] mode_bits(compress_mode_t m);
        logic [3:0] d;
        case (m)
            comp_d1:  d = 4'd1;
            comp_d5:  d = 4'd5;
            comp_d10: d = 4'd10;
            default:  d = 4'd11;
        endcase
        return d;
    endfunction

endpackage

`default_nettype wire

// ==== compress_coeff.sv ====
// ----------------------------------------------------------
// single coefficient compressor, round(x * 2^d / q) mod 2^d
// ----------------------------------------------------------
`default_nettype none

module compress_coeff
    import compress_pkg::*;
(
    input  wire logic [reg_size-1:0]   coeff,
    input  wire compress_mode_t        mode,
    output logic      [comp_max_d-1:0] comp
);

    logic [3:0]                 d;
    logic [comp_num_width-1:0]  num;
    logic [comp_prod_width-1:0] prod;
    logic [comp_num_width-1:0]  q_est;
    logic [comp_num_width-1:0]  rem;
    logic [comp_max_d:0]        quot;
    logic [comp_max_d-1:0]      mask;

    always_comb begin
        d = mode_bits(mode);
        // scale up and add q/2 so the floor division rounds to nearest
        num = (comp_num_width'(coeff) << d) + comp_num_width'(mlkem_q / 2);
        // floor(num / q) estimate, low by at most one
        prod  = comp_prod_width'(num) * comp_prod_width'(comp_recip);
        q_est = comp_num_width'(prod >> comp_recip_shift);
        rem   = num - q_est * comp_num_width'(mlkem_q);
        // correction step when the remainder still holds a full q
        if (rem >= comp_num_width'(mlkem_q)) begin
            quot = q_est[comp_max_d:0] + 1'b1;
        end else begin
            quot = q_est[comp_max_d:0];
        end
        // mod 2^d, top values wrap to zero
        mask = comp_max_d'((1 << d) - 1);
        comp = quot[comp_max_d-1:0] & mask;
    end

endmodule

`default_nettype wire

// ==== compress_ctrl.sv ====
// ----------------------------------------------------------
// job sequencer with memory read stream and aligned item flags
// ----------------------------------------------------------
`default_nettype none

module compress_ctrl
    import compress_pkg::*;
(
    input  wire logic                      pi_clk,
    input  wire logic                      pi_reset_n,
    input  wire logic                      zeroize,
    input  wire logic                      compress_enable,
    input  wire logic [num_poly_width-1:0] num_poly,
    input  wire logic [mem_addr_width-1:0] src_base_addr,
    input  wire logic [mem_addr_width-1:0] dest_base_addr,
    output logic                           mem_rd_en,
    output logic      [mem_addr_width-1:0] mem_rd_addr,
    output logic                           item_valid,
    output logic                           item_last,
    output logic      [mem_addr_width-1:0] item_addr
);

    logic                      busy;
    logic [word_cnt_width-1:0] word_cnt;
    logic [word_cnt_width-1:0] word_total;
    logic [mem_addr_width-1:0] rd_addr;
    logic                      last_word;

    // N = num_poly * 64
    // inputs held stable while busy
    assign word_total = {num_poly, {word_idx_width{1'b0}}};
    assign last_word  = (word_cnt == word_total - 1'b1);

    // one read per cycle for as long as the job runs
    assign mem_rd_en   = busy;
    assign mem_rd_addr = rd_addr;

    // ------------------------------------------------------
    // read sequencing and one-stage flag delay
    // ------------------------------------------------------
    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            busy       <= 1'b0;
            word_cnt   <= '0;
            rd_addr    <= '0;
            item_valid <= 1'b0;
            item_last  <= 1'b0;
        end else if (zeroize) begin
            busy       <= 1'b0;
            word_cnt   <= '0;
            rd_addr    <= '0;
            item_valid <= 1'b0;
            item_last  <= 1'b0;
        end else begin
            // flags follow the read data by one cycle
            item_valid <= busy;
            item_last  <= busy && last_word;
            if (compress_enable) begin
                busy     <= 1'b1;
                word_cnt <= '0;
                rd_addr  <= src_base_addr;
            end else if (busy) begin
                if (last_word) begin
                    busy <= 1'b0;
                end
                word_cnt <= word_cnt + 1'b1;
                rd_addr  <= rd_addr + 1'b1;
            end
        end
    end

    // destination follows the word index
    always_ff @(posedge pi_clk) begin
        item_addr <= dest_base_addr + mem_addr_width'(word_cnt);
    end

endmodule

`default_nettype wire

// ==== compress_api_port.sv ====
// ----------------------------------------------------------
// API output stage: write or read-back compare, sticky
// mismatch flag and done pulse
// ----------------------------------------------------------
`default_nettype none

module compress_api_port
    import compress_pkg::*;
(
    input  wire logic                      pi_clk,
    input  wire logic                      pi_reset_n,
    input  wire logic                      zeroize,
    input  wire logic                      compress_enable,
    input  wire logic                      compare_mode,
    input  wire logic                      item_valid,
    input  wire logic                      item_last,
    input  wire logic [mem_addr_width-1:0] item_addr,
    input  wire logic [api_data_width-1:0] comp_word,
    input  wire logic [api_data_width-1:0] api_rd_data,
    output logic      [1:0]                api_rw_en,
    output logic      [mem_addr_width-1:0] api_rw_addr,
    output logic      [api_data_width-1:0] api_wr_data,
    output logic                           compare_failed,
    output logic                           compress_done
);

    logic                      acc_last;
    logic                      acc_read;
    logic                      cmp_valid;
    logic                      cmp_last;
    logic                      done_q;
    logic                      failed_q;
    logic [api_data_width-1:0] exp_word;
    logic                      mismatch;

    // access stage is a read when the enable code says so
    assign acc_read = (api_rw_en == api_en_read);
    // read data lines up with the held expected word
    assign mismatch = cmp_valid && (exp_word != api_rd_data);

    assign compare_failed = failed_q;
    assign compress_done  = done_q;

    // ------------------------------------------------------
    // access, compare and done control
    // ------------------------------------------------------
    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            api_rw_en <= 2'b00;
            acc_last  <= 1'b0;
            cmp_valid <= 1'b0;
            cmp_last  <= 1'b0;
            done_q    <= 1'b0;
            failed_q  <= 1'b0;
        end else if (zeroize) begin
            api_rw_en <= 2'b00;
            acc_last  <= 1'b0;
            cmp_valid <= 1'b0;
            cmp_last  <= 1'b0;
            done_q    <= 1'b0;
            failed_q  <= 1'b0;
        end else begin
            if (item_valid) begin
                api_rw_en <= compare_mode ? api_en_read : api_en_write;
            end else begin
                api_rw_en <= 2'b00;
            end
            acc_last  <= item_valid && item_last;
            cmp_valid <= acc_read;
            cmp_last  <= acc_read && acc_last;
            // write mode ends after the last access, compare one later
            done_q    <= (acc_last && !acc_read) || cmp_last;
            // sticky until the next job starts
            if (compress_enable) begin
                failed_q <= 1'b0;
            end else if (mismatch) begin
                failed_q <= 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge pi_clk) begin
        if (item_valid) begin
            api_rw_addr <= item_addr;
            api_wr_data <= comp_word;
        end
        // expected word for the compare one cycle later
        exp_word <= api_wr_data;
    end

endmodule

`default_nettype wire

// ==== compress_top.sv ====
// ----------------------------------------------------------
// compression unit top: sequencer, four lane compressors
// and the API stage
// ----------------------------------------------------------
`default_nettype none

module compress_top
    import compress_pkg::*;
(
    input  wire logic                                    pi_clk,
    input  wire logic                                    pi_reset_n,
    input  wire logic                                    zeroize,
    input  wire logic                                    compress_enable,
    input  wire compress_mode_t                          mode,
    input  wire logic                                    compare_mode,
    input  wire logic [num_poly_width-1:0]               num_poly,
    input  wire logic [mem_addr_width-1:0]               src_base_addr,
    input  wire logic [mem_addr_width-1:0]               dest_base_addr,
    output logic                                         mem_rd_en,
    output logic      [mem_addr_width-1:0]               mem_rd_addr,
    input  wire logic [coeff_per_clk-1:0][reg_size-1:0]  mem_rd_data,
    output logic      [1:0]                              api_rw_en,
    output logic      [mem_addr_width-1:0]               api_rw_addr,
    output logic      [api_data_width-1:0]               api_wr_data,
    input  wire logic [api_data_width-1:0]               api_rd_data,
    output logic                                         compare_failed,
    output logic                                         compress_done
);

    logic                                   item_valid;
    logic                                   item_last;
    logic [mem_addr_width-1:0]              item_addr;
    // lane 0 lands in the low bits of the API word
    logic [coeff_per_clk-1:0][comp_max_d-1:0] comp_lane;

    compress_ctrl u_ctrl (
        .pi_clk          (pi_clk),
        .pi_reset_n      (pi_reset_n),
        .zeroize         (zeroize),
        .compress_enable (compress_enable),
        .num_poly        (num_poly),
        .src_base_addr   (src_base_addr),
        .dest_base_addr  (dest_base_addr),
        .mem_rd_en       (mem_rd_en),
        .mem_rd_addr     (mem_rd_addr),
        .item_valid      (item_valid),
        .item_last       (item_last),
        .item_addr       (item_addr)
    );

    // one compressor per coefficient lane
    for (genvar i = 0; i < coeff_per_clk; i++) begin : g_lane
        compress_coeff u_coeff (
            .coeff (mem_rd_data[i]),
            .mode  (mode),
            .comp  (comp_lane[i])
        );
    end

    compress_api_port u_api (
        .pi_clk          (pi_clk),
        .pi_reset_n      (pi_reset_n),
        .zeroize         (zeroize),
        .compress_enable (compress_enable),
        .compare_mode    (compare_mode),
        .item_valid      (item_valid),
        .item_last       (item_last),
        .item_addr       (item_addr),
        .comp_word       (comp_lane),
        .api_rd_data     (api_rd_data),
        .api_rw_en       (api_rw_en),
        .api_rw_addr     (api_rw_addr),
        .api_wr_data     (api_wr_data),
        .compare_failed  (compare_failed),
        .compress_done   (compress_done)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// ----------------------------------------------------------
// testbench clock, period 8, and reset for 10 cycles
// ----------------------------------------------------------
`default_nettype none

module tb_clock_gen (
    output logic pi_clk,
    output logic pi_reset_n
);

    // free running clock
    initial begin
        pi_clk = 1'b0;
        forever #4 pi_clk = ~pi_clk;
    end

    // reset low from time zero, released on a rising edge
    initial begin
        pi_reset_n <= 1'b0;
        repeat (10) @(posedge pi_clk);
        pi_reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== compress_sva.sv ====
// ----------------------------------------------------------
// protocol assertions bound to the compression unit top
// ----------------------------------------------------------
`default_nettype none

module compress_sva (
    input wire logic       pi_clk,
    input wire logic       pi_reset_n,
    input wire logic       zeroize,
    input wire logic       compress_enable,
    input wire logic       mem_rd_en,
    input wire logic [1:0] api_rw_en,
    input wire logic       compare_failed,
    input wire logic       compress_done
);

    // a job is open from its enable up to its done pulse
    logic job_open;

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            job_open <= 1'b0;
        end else if (zeroize || compress_done) begin
            job_open <= 1'b0;
        end else if (compress_enable) begin
            job_open <= 1'b1;
        end
    end

    // no new job while one is running
    enable_when_idle: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
        compress_enable |-> !job_open)
        else $error("compress_enable seen while a job was running");

    // code 11 is never a legal API enable
    legal_api_code: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
        api_rw_en != 2'b11)
        else $error("api_rw_en carries the unused code 11");

    // done only closes an open job, and only for one cycle
    done_needs_job: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
        compress_done |-> job_open)
        else $error("compress_done without a matching enable");
    done_single: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
        compress_done |=> !compress_done)
        else $error("compress_done held longer than one cycle");

    // reset or zeroize leaves every status output inactive
    outputs_idle: assert property (@(posedge pi_clk)
        (!pi_reset_n || zeroize) |=> (!mem_rd_en && api_rw_en == 2'b00
                                      && !compress_done && !compare_failed))
        else $error("outputs active right after reset or zeroize");

endmodule

bind compress_top compress_sva u_sva (
    .pi_clk          (pi_clk),
    .pi_reset_n      (pi_reset_n),
    .zeroize         (zeroize),
    .compress_enable (compress_enable),
    .mem_rd_en       (mem_rd_en),
    .api_rw_en       (api_rw_en),
    .compare_failed  (compare_failed),
    .compress_done   (compress_done)
);

`default_nettype wire

// ==== compress_tb.sv ====
// ----------------------------------------------------------
// compression unit testbench with memory and API models, LFSR
// stimulus, reference packing, checker and watchdog
// ----------------------------------------------------------
`default_nettype none

module compress_tb
    import compress_pkg::*;
();

    // ten jobs with 1024 words over all of them
    localparam int job_count = 10;
    localparam int job_words = 1024;

    logic                                   pi_clk;
    logic                                   pi_reset_n;
    logic                                   zeroize;
    logic                                   compress_enable;
    compress_mode_t                         mode;
    logic                                   compare_mode;
    logic [num_poly_width-1:0]              num_poly;
    logic [mem_addr_width-1:0]              src_base_addr;
    logic [mem_addr_width-1:0]              dest_base_addr;
    logic                                   mem_rd_en;
    logic [mem_addr_width-1:0]              mem_rd_addr;
    logic [coeff_per_clk-1:0][reg_size-1:0] mem_rd_data;
    logic [1:0]                             api_rw_en;
    logic [mem_addr_width-1:0]              api_rw_addr;
    logic [api_data_width-1:0]              api_wr_data;
    logic [api_data_width-1:0]              api_rd_data;
    logic                                   compare_failed;
    logic                                   compress_done;

    logic [coeff_per_clk-1:0][reg_size-1:0] src_mem [0:(1<<mem_addr_width)-1];
    logic [api_data_width-1:0]              api_mem [0:(1<<mem_addr_width)-1];

    // ------------------------------------------------------
    // checker state captured at each enable
    // ------------------------------------------------------
    int                        cyc = 0;
    int                        en_cyc = -100;
    int                        rd_cnt = 0;
    int                        acc_cnt = 0;
    int                        done_cnt = 0;
    int                        job_n = 0;
    logic                      active = 1'b0;
    logic                      exp_fail = 1'b0;
    logic                      job_cmp;
    compress_mode_t            job_mode;
    logic [mem_addr_width-1:0] job_src;
    logic [mem_addr_width-1:0] job_dst;

    tb_clock_gen u_clk (
        .pi_clk     (pi_clk),
        .pi_reset_n (pi_reset_n)
    );

    compress_top dut (.*);

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // packing of one source word with lane i at bits i*11 upward
    function automatic logic [api_data_width-1:0] expected_word(input int addr,
                                                                input compress_mode_t m);
        logic [api_data_width-1:0] w;
        int d;
        int x;
        int i;
        d = (m == comp_d1) ? 1 : (m == comp_d5) ? 5 : (m == comp_d10) ? 10 : 11;
        w = '0;
        for (i = 0; i < coeff_per_clk; i++) begin
            // q is odd so round(x * 2^d / q) has no ties
            x = ((int'(src_mem[addr][i]) << d) + mlkem_q / 2) / mlkem_q;
            w[i*comp_max_d +: comp_max_d] = comp_max_d'(x % (1 << d));
        end
        return w;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // ------------------------------------------------------
    // memory models
    // ------------------------------------------------------
    // coefficient memory returns data one cycle after the read
    always @(posedge pi_clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= src_mem[mem_rd_addr];
        end
    end

    // API memory takes writes at the edge and returns reads a cycle later
    always @(posedge pi_clk) begin
        if (api_rw_en == api_en_write) begin
            api_mem[api_rw_addr] <= api_wr_data;
        end
        if (api_rw_en == api_en_read) begin
            api_rd_data <= api_mem[api_rw_addr];
        end
    end

    // ------------------------------------------------------
    // comparing process
    // ------------------------------------------------------
    always @(posedge pi_clk) begin : check_proc
        logic [api_data_width-1:0] exp_word;
        cyc = cyc + 1;
        if (pi_reset_n) begin
            if (mem_rd_en) begin
                assert (active) else stop_on_error("memory read while no job was running");
                assert (mem_rd_addr == job_src + mem_addr_width'(rd_cnt))
                    else stop_on_error($sformatf("Error: mem_rd_addr expected %h got %h",
                                                 job_src + mem_addr_width'(rd_cnt),
                                                 mem_rd_addr));
                // reads run back to back from one cycle after the enable
                assert (cyc == en_cyc + 1 + rd_cnt)
                    else stop_on_error("memory read came at the wrong cycle");
                rd_cnt = rd_cnt + 1;
            end
            if (api_rw_en != 2'b00) begin
                assert (active) else stop_on_error("API access while no job was running");
                assert (api_rw_en == (job_cmp ? api_en_read : api_en_write))
                    else stop_on_error($sformatf("Error: api_rw_en expected %h got %h",
                                                 job_cmp ? api_en_read : api_en_write,
                                                 api_rw_en));
                assert (api_rw_addr == job_dst + mem_addr_width'(acc_cnt))
                    else stop_on_error($sformatf("Error: api_rw_addr expected %h got %h",
                                                 job_dst + mem_addr_width'(acc_cnt),
                                                 api_rw_addr));
                // first access three cycles after the enable
                if (acc_cnt == 0) begin
                    assert (cyc == en_cyc + 3)
                        else stop_on_error("first API access came at the wrong cycle");
                end
                if (api_rw_en == api_en_write) begin
                    exp_word = expected_word(int'(job_src) + acc_cnt, job_mode);
                    assert (api_wr_data == exp_word)
                        else stop_on_error($sformatf("Error: api_wr_data expected %h got %h",
                                                     exp_word, api_wr_data));
                end
                acc_cnt = acc_cnt + 1;
            end
            if (compress_done) begin
                assert (active) else stop_on_error("done pulse without a running job");
                assert (rd_cnt == job_n)
                    else stop_on_error($sformatf("Error: mem_rd_en count expected %h got %h",
                                                 job_n, rd_cnt));
                assert (acc_cnt == job_n)
                    else stop_on_error($sformatf("Error: API access count expected %h got %h",
                                                 job_n, acc_cnt));
                // N+3 in write mode and one more in compare mode
                assert (cyc - en_cyc == job_n + 3 + int'(job_cmp))
                    else stop_on_error($sformatf("Error: compress_done delay expected %h got %h",
                                                 job_n + 3 + int'(job_cmp), cyc - en_cyc));
                if (job_cmp) begin
                    assert (compare_failed == exp_fail)
                        else stop_on_error($sformatf("Error: compare_failed expected %h got %h",
                                                     exp_fail, compare_failed));
                end
                active   = 1'b0;
                done_cnt = done_cnt + 1;
            end
            // sticky flag drops right after a new enable
            if (cyc == en_cyc + 1) begin
                assert (!compare_failed)
                    else stop_on_error($sformatf("Error: compare_failed expected 0 got %h",
                                                 compare_failed));
            end
            if (zeroize) begin
                active = 1'b0;
            end
            if (compress_enable) begin
                active   = 1'b1;
                en_cyc   = cyc;
                rd_cnt   = 0;
                acc_cnt  = 0;
                job_n    = int'(num_poly) * words_per_poly;
                job_cmp  = compare_mode;
                job_mode = mode;
                job_src  = src_base_addr;
                job_dst  = dest_base_addr;
            end
        end
    end

    // ------------------------------------------------------
    // stimulus
    // ------------------------------------------------------
    task automatic start_job(input compress_mode_t m, input logic cmp,
                             input logic [num_poly_width-1:0] np,
                             input logic [mem_addr_width-1:0] src,
                             input logic [mem_addr_width-1:0] dst);
        @(posedge pi_clk);
        mode            <= m;
        compare_mode    <= cmp;
        num_poly        <= np;
        src_base_addr   <= src;
        dest_base_addr  <= dst;
        compress_enable <= 1'b1;
        @(posedge pi_clk);
        compress_enable <= 1'b0;
    endtask

    task automatic run_job(input compress_mode_t m, input logic cmp,
                           input logic [num_poly_width-1:0] np,
                           input logic [mem_addr_width-1:0] src,
                           input logic [mem_addr_width-1:0] dst, input logic fail);
        exp_fail = fail;
        start_job(m, cmp, np, src, dst);
        do begin
            @(posedge pi_clk);
        end while (!compress_done);
        @(posedge pi_clk);
    endtask

    initial begin
        logic [15:0]         lfsr;
        logic [reg_size-1:0] c;
        int                  a;
        int                  i;
        int                  b;
        zeroize         <= 1'b0;
        compress_enable <= 1'b0;
        mode            <= comp_d1;
        compare_mode    <= 1'b0;
        num_poly        <= 3'd1;
        src_base_addr   <= '0;
        dest_base_addr  <= '0;
        mem_rd_data     <= '0;
        api_rd_data     <= '0;
        // coefficient image with 12 LFSR bits each reduced below q
        lfsr = 16'd30180;
        for (a = 0; a < (1 << mem_addr_width); a++) begin
            for (i = 0; i < coeff_per_clk; i++) begin
                for (b = 0; b < reg_size; b++) begin
                    lfsr = lfsr_next(lfsr);
                    c    = {c[reg_size-2:0], lfsr[0]};
                end
                src_mem[a][i] = c % reg_size'(mlkem_q);
            end
        end
        @(posedge pi_reset_n);
        repeat (2) @(posedge pi_clk);
        // one polynomial in each mode
        run_job(comp_d1, 1'b0, 3'd1, 10'd0, 10'd0, 1'b0);
        run_job(comp_d5, 1'b0, 3'd1, 10'd0, 10'd0, 1'b0);
        run_job(comp_d10, 1'b0, 3'd1, 10'd0, 10'd0, 1'b0);
        run_job(comp_d11, 1'b0, 3'd1, 10'd0, 10'd0, 1'b0);
        // three polynomials at offset bases and then read back
        run_job(comp_d10, 1'b0, 3'd3, 10'd100, 10'd300, 1'b0);
        run_job(comp_d10, 1'b1, 3'd3, 10'd100, 10'd300, 1'b0);
        // flip one stored bit and then let a clean region clear the flag
        api_mem[305] <= api_mem[305] ^ 44'h1;
        run_job(comp_d10, 1'b1, 3'd1, 10'd100, 10'd300, 1'b1);
        run_job(comp_d10, 1'b1, 3'd1, 10'd164, 10'd364, 1'b0);
        // abort a job halfway and let the checker flag any late write or done
        start_job(comp_d5, 1'b0, 3'd2, 10'd500, 10'd600);
        repeat (20) @(posedge pi_clk);
        zeroize <= 1'b1;
        @(posedge pi_clk);
        zeroize <= 1'b0;
        repeat (100) @(posedge pi_clk);
        run_job(comp_d5, 1'b0, 3'd2, 10'd500, 10'd600, 1'b0);
        // every job except the aborted one ends with a done pulse
        if (done_cnt == job_count - 1) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error($sformatf("Error: done pulse count expected %h got %h",
                                    job_count - 1, done_cnt));
        end
    end

    // watchdog over 8 * (N + 20) summed over all jobs
    initial begin
        #(8 * (job_words + 20 * job_count));
        stop_on_error("watchdog expired before all jobs finished");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
compress_pkg.sv
compress_coeff.sv
compress_ctrl.sv
compress_api_port.sv
compress_top.sv
tb_clock_gen.sv
compress_sva.sv
compress_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the compression unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module compress_tb --Mdir obj_dir -o compress_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/compress_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
